// ==== hw/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// datapath and register file geometry.
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// performance counters.
`define COUNT_W     32
`define NUM_CLASSES 7

// rv32i base opcodes.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_SYSTEM  7'b1110011

`endif

// ==== hw/rv_decode_pkg.sv ====
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [31:0]            inst_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [6:0]             opcode_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [`COUNT_W-1:0]    count_t;

    // 0 R, 1 I, 2 S, 3 B, 4 U, 5 J, 6 SYSTEM.
    typedef logic [2:0]             class_sel_t;

    ////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_eq
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_reg,
        src1_pc,
        src1_zero
    } src1_sel_t;

    typedef enum logic {
        slot_empty,
        slot_full
    } slot_state_t;

endpackage

// ==== hw/decode_slot.sv ====
`timescale 1ns/1ns

module decode_slot (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  rv_decode_pkg::inst_t inst,
    input  rv_decode_pkg::word_t pc,
    input  logic                 flush,
    input  logic                 out_ready,
    output logic                 in_ready,
    output logic                 out_valid,
    output logic                 delivered,
    output rv_decode_pkg::inst_t slot_inst,
    output rv_decode_pkg::word_t slot_pc
);

    rv_decode_pkg::slot_state_t state;
    logic                       kill_armed;
    logic                       accept;
    logic                       kill_now;
    logic                       capture;

    assign out_valid = (state == rv_decode_pkg::slot_full);
    assign in_ready  = !out_valid || out_ready;
    assign delivered = out_valid && out_ready;
    assign accept    = in_valid && in_ready;

    // a flush in the accept cycle kills that same instruction.
    assign kill_now  = flush || kill_armed;
    assign capture   = accept && !kill_now;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= rv_decode_pkg::slot_empty;
            kill_armed <= 1'b0;
        end else begin
            if (capture) begin
                state <= rv_decode_pkg::slot_full;
            end else if (delivered) begin
                state <= rv_decode_pkg::slot_empty;
            end

            // killed instruction is consumed and disarms the flag.
            if (accept) begin
                kill_armed <= 1'b0;
            end else if (flush) begin
                kill_armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            slot_inst <= inst;
            slot_pc   <= pc;
        end
    end

endmodule

// ==== hw/inst_class_counters.sv ====
`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module inst_class_counters (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       delivered,
    input  rv_decode_pkg::opcode_t     opcode,
    input  rv_decode_pkg::class_sel_t  count_sel,
    output rv_decode_pkg::count_t      count_value
);

    rv_decode_pkg::count_t     counts [`NUM_CLASSES];
    rv_decode_pkg::class_sel_t cls;
    logic                      cls_hit;

    ////////////////////////////////////////////////////////////
    // opcode to class
    ////////////////////////////////////////////////////////////

    always_comb begin
        cls     = 3'd0;
        cls_hit = 1'b1;
        case (opcode)
            `OPC_OP:     cls = 3'd0;
            `OPC_LOAD,
            `OPC_OP_IMM,
            `OPC_JALR:   cls = 3'd1;
            `OPC_STORE:  cls = 3'd2;
            `OPC_BRANCH: cls = 3'd3;
            `OPC_LUI,
            `OPC_AUIPC:  cls = 3'd4;
            `OPC_JAL:    cls = 3'd5;
            `OPC_SYSTEM: cls = 3'd6;
            default:     cls_hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    // wrap on overflow.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_CLASSES; i++) begin
                counts[i] <= '0;
            end
        end else if (delivered && cls_hit) begin
            counts[cls] <= counts[cls] + 1'b1;
        end
    end

    // select 7 has no counter behind it.
    always_comb begin
        if (count_sel < `NUM_CLASSES) begin
            count_value = counts[count_sel];
        end else begin
            count_value = '0;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module imm_gen (
    input  rv_decode_pkg::inst_t slot_inst,
    output rv_decode_pkg::word_t imm
);

    rv_decode_pkg::opcode_t opcode;
    rv_decode_pkg::funct3_t funct3;
    logic                   sign;

    assign opcode = slot_inst[6:0];
    assign funct3 = slot_inst[14:12];
    assign sign   = slot_inst[31];

    always_comb begin
        case (opcode)
            `OPC_LOAD, `OPC_JALR, `OPC_SYSTEM: begin
                imm = {{20{sign}}, slot_inst[31:20]};
            end
            `OPC_OP_IMM: begin
                // shift amount only for slli, srli and srai.
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm = {27'd0, slot_inst[24:20]};
                end else begin
                    imm = {{20{sign}}, slot_inst[31:20]};
                end
            end
            `OPC_STORE: begin
                imm = {{20{sign}}, slot_inst[31:25], slot_inst[11:7]};
            end
            `OPC_BRANCH: begin
                imm = {{19{sign}}, sign, slot_inst[7], slot_inst[30:25],
                       slot_inst[11:8], 1'b0};
            end
            `OPC_JAL: begin
                imm = {{11{sign}}, sign, slot_inst[19:12], slot_inst[20],
                       slot_inst[30:21], 1'b0};
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm = {slot_inst[31:12], 12'd0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== hw/ctrl_decode.sv ====
`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module ctrl_decode (
    input  rv_decode_pkg::inst_t      slot_inst,
    output rv_decode_pkg::reg_addr_t  rs1,
    output rv_decode_pkg::reg_addr_t  rs2,
    output rv_decode_pkg::reg_addr_t  rd,
    output rv_decode_pkg::funct3_t    funct3,
    output logic                      reg_wen,
    output logic                      mem_wen,
    output logic                      mem_ren,
    output logic                      branch,
    output logic                      jump,
    output logic                      inv_flag,
    output rv_decode_pkg::src1_sel_t  src1_sel,
    output logic                      src2_imm,
    output rv_decode_pkg::alu_op_t    alu_op
);

    rv_decode_pkg::opcode_t opcode;
    logic                   alt;
    logic                   is_op;
    logic                   is_op_imm;

    assign opcode    = slot_inst[6:0];
    assign rd        = slot_inst[11:7];
    assign funct3    = slot_inst[14:12];
    assign rs1       = slot_inst[19:15];
    assign rs2       = slot_inst[24:20];
    assign alt       = slot_inst[30];
    assign is_op     = (opcode == `OPC_OP);
    assign is_op_imm = (opcode == `OPC_OP_IMM);

    ////////////////////////////////////////////////////////////
    // control flags
    ////////////////////////////////////////////////////////////

    assign mem_wen = (opcode == `OPC_STORE);
    assign mem_ren = (opcode == `OPC_LOAD);
    assign branch  = (opcode == `OPC_BRANCH);
    assign jump    = (opcode == `OPC_JAL) || (opcode == `OPC_JALR);
    assign reg_wen = !(mem_wen || branch || opcode == 7'd0);

    // beq, bge and bgeu test the inverted compare.
    assign inv_flag = branch && (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);

    assign src2_imm = !(is_op || branch);

    always_comb begin
        case (opcode)
            `OPC_LUI:             src1_sel = rv_decode_pkg::src1_zero;
            `OPC_AUIPC, `OPC_JAL: src1_sel = rv_decode_pkg::src1_pc;
            default:              src1_sel = rv_decode_pkg::src1_reg;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // alu operation
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op = rv_decode_pkg::alu_add;
        if (is_op || is_op_imm) begin
            case (funct3)
                // addi has no subtract form.
                3'b000:  alu_op = (is_op && alt) ? rv_decode_pkg::alu_sub
                                                 : rv_decode_pkg::alu_add;
                3'b001:  alu_op = rv_decode_pkg::alu_sll;
                3'b010:  alu_op = rv_decode_pkg::alu_slt;
                3'b011:  alu_op = rv_decode_pkg::alu_sltu;
                3'b100:  alu_op = rv_decode_pkg::alu_xor;
                3'b101:  alu_op = alt ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
                3'b110:  alu_op = rv_decode_pkg::alu_or;
                default: alu_op = rv_decode_pkg::alu_and;
            endcase
        end else if (branch) begin
            case (funct3[2:1])
                2'b00:   alu_op = rv_decode_pkg::alu_eq;
                2'b10:   alu_op = rv_decode_pkg::alu_slt;
                2'b11:   alu_op = rv_decode_pkg::alu_sltu;
                default: alu_op = rv_decode_pkg::alu_add;
            endcase
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module reg_file (
    input  logic                      clock,
    input  logic                      reset,
    input  rv_decode_pkg::reg_addr_t  rs1,
    input  rv_decode_pkg::reg_addr_t  rs2,
    input  logic                      wen,
    input  rv_decode_pkg::reg_addr_t  wd_addr,
    input  rv_decode_pkg::word_t      wd_data,
    output rv_decode_pkg::word_t      rs1_value,
    output rv_decode_pkg::word_t      rs2_value
);

    rv_decode_pkg::word_t regs [`REG_COUNT];

    // x0 is never written.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wd_addr != '0) begin
            regs[wd_addr] <= wd_data;
        end
    end

    // no bypass from the write port.
    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    input  rv_decode_pkg::inst_t       inst,
    input  rv_decode_pkg::word_t       pc,
    input  logic                       flush,
    input  logic                       out_ready,
    input  logic                       wb_wen,
    input  rv_decode_pkg::reg_addr_t   wb_rd,
    input  rv_decode_pkg::word_t       wb_data,
    input  rv_decode_pkg::class_sel_t  count_sel,
    output logic                       in_ready,
    output logic                       out_valid,
    output rv_decode_pkg::word_t       pc_out,
    output rv_decode_pkg::reg_addr_t   rd,
    output rv_decode_pkg::reg_addr_t   rs1,
    output rv_decode_pkg::reg_addr_t   rs2,
    output rv_decode_pkg::funct3_t     funct3,
    output rv_decode_pkg::word_t       imm,
    output rv_decode_pkg::word_t       rs1_value,
    output rv_decode_pkg::word_t       rs2_value,
    output logic                       reg_wen,
    output logic                       mem_wen,
    output logic                       mem_ren,
    output logic                       branch,
    output logic                       jump,
    output logic                       inv_flag,
    output rv_decode_pkg::src1_sel_t   src1_sel,
    output logic                       src2_imm,
    output rv_decode_pkg::alu_op_t     alu_op,
    output rv_decode_pkg::count_t      count_value
);

    rv_decode_pkg::inst_t slot_inst;
    logic                 delivered;

    ////////////////////////////////////////////////////////////
    // pipeline slot
    ////////////////////////////////////////////////////////////

    decode_slot decode_slot_inst (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .flush     (flush),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .delivered (delivered),
        .slot_inst (slot_inst),
        .slot_pc   (pc_out)
    );

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    ctrl_decode ctrl_decode_inst (
        .slot_inst (slot_inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .funct3    (funct3),
        .reg_wen   (reg_wen),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .branch    (branch),
        .jump      (jump),
        .inv_flag  (inv_flag),
        .src1_sel  (src1_sel),
        .src2_imm  (src2_imm),
        .alu_op    (alu_op)
    );

    imm_gen imm_gen_inst (
        .slot_inst (slot_inst),
        .imm       (imm)
    );

    // operands read with the slot's own register fields.
    reg_file reg_file_inst (
        .clock     (clock),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .wen       (wb_wen),
        .wd_addr   (wb_rd),
        .wd_data   (wb_data),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    inst_class_counters inst_class_counters_inst (
        .clock       (clock),
        .reset       (reset),
        .delivered   (delivered),
        .opcode      (slot_inst[6:0]),
        .count_sel   (count_sel),
        .count_value (count_value)
    );

endmodule

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/1ns

`include "rv_decode_macros.svh"

module decode_stage_tb;

    localparam int rand_cycles     = 400;
    localparam int directed_cycles = 200;
    localparam int cycle_limit     = 2 * (rand_cycles + directed_cycles) + 100;
    localparam rv_decode_pkg::opcode_t opcode_table [10] = '{
        `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
        `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP, `OPC_SYSTEM
    };

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       in_valid;
    rv_decode_pkg::inst_t       inst;
    rv_decode_pkg::word_t       pc;
    logic                       flush;
    logic                       out_ready;
    logic                       wb_wen;
    rv_decode_pkg::reg_addr_t   wb_rd;
    rv_decode_pkg::word_t       wb_data;
    rv_decode_pkg::class_sel_t  count_sel;
    logic                       in_ready;
    logic                       out_valid;
    rv_decode_pkg::word_t       pc_out;
    rv_decode_pkg::reg_addr_t   rd;
    rv_decode_pkg::reg_addr_t   rs1;
    rv_decode_pkg::reg_addr_t   rs2;
    rv_decode_pkg::funct3_t     funct3;
    rv_decode_pkg::word_t       imm;
    rv_decode_pkg::word_t       rs1_value;
    rv_decode_pkg::word_t       rs2_value;
    logic                       reg_wen;
    logic                       mem_wen;
    logic                       mem_ren;
    logic                       branch;
    logic                       jump;
    logic                       inv_flag;
    rv_decode_pkg::src1_sel_t   src1_sel;
    logic                       src2_imm;
    rv_decode_pkg::alu_op_t     alu_op;
    rv_decode_pkg::count_t      count_value;

    // model state.
    logic [63:0]                pending [$];
    logic                       head_valid;
    rv_decode_pkg::inst_t       head_inst;
    rv_decode_pkg::word_t       head_pc;
    logic                       loaded;
    logic                       kill_armed;
    rv_decode_pkg::word_t       model_regs [32];
    rv_decode_pkg::count_t      model_counts [8];
    rv_decode_pkg::word_t       next_pc = 32'h0000_1000;
    logic [31:0]                lfsr = 32'h5438;
    int                         cycle_count = 0;

    rv_decode_pkg::opcode_t     head_opc;
    rv_decode_pkg::word_t       exp_imm;
    rv_decode_pkg::alu_op_t     exp_alu;
    rv_decode_pkg::src1_sel_t   exp_src1;
    rv_decode_pkg::count_t      exp_count;

    always #50 clock = ~clock;

    decode_stage decode_stage_inst (.*);

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    function automatic rv_decode_pkg::word_t model_imm(input rv_decode_pkg::inst_t w);
        rv_decode_pkg::word_t i_imm;
        i_imm = rv_decode_pkg::word_t'($signed(w) >>> 20);
        case (w[6:0])
            `OPC_LOAD, `OPC_JALR, `OPC_SYSTEM: return i_imm;
            `OPC_OP_IMM: return (w[13:12] == 2'b01) ? {27'd0, w[24:20]} : i_imm;
            `OPC_STORE:  return {i_imm[31:5], w[11:7]};
            `OPC_BRANCH: return {i_imm[31:12], w[7], i_imm[10:5], w[11:8], 1'b0};
            `OPC_JAL:    return {i_imm[31:20], w[19:12], w[20], w[30:21], 1'b0};
            `OPC_LUI, `OPC_AUIPC: return w & 32'hffff_f000;
            default:     return '0;
        endcase
    endfunction

    function automatic rv_decode_pkg::alu_op_t model_alu(input rv_decode_pkg::inst_t w);
        if (w[6:0] == `OPC_BRANCH) begin
            case (w[14:13])
                2'b00:   return rv_decode_pkg::alu_eq;
                2'b10:   return rv_decode_pkg::alu_slt;
                2'b11:   return rv_decode_pkg::alu_sltu;
                default: return rv_decode_pkg::alu_add;
            endcase
        end
        if (w[6:0] != `OPC_OP && w[6:0] != `OPC_OP_IMM) begin
            return rv_decode_pkg::alu_add;
        end
        case (w[14:12])
            3'b000: return (w[6:0] == `OPC_OP && w[30]) ? rv_decode_pkg::alu_sub
                                                       : rv_decode_pkg::alu_add;
            3'b001: return rv_decode_pkg::alu_sll;
            3'b010: return rv_decode_pkg::alu_slt;
            3'b011: return rv_decode_pkg::alu_sltu;
            3'b100: return rv_decode_pkg::alu_xor;
            3'b101: return w[30] ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
            3'b110: return rv_decode_pkg::alu_or;
            default: return rv_decode_pkg::alu_and;
        endcase
    endfunction

    // 7 means no class.
    function automatic int class_of(input rv_decode_pkg::opcode_t opc);
        case (opc)
            `OPC_OP: return 0;
            `OPC_LOAD, `OPC_OP_IMM, `OPC_JALR: return 1;
            `OPC_STORE: return 2;
            `OPC_BRANCH: return 3;
            `OPC_LUI, `OPC_AUIPC: return 4;
            `OPC_JAL: return 5;
            `OPC_SYSTEM: return 6;
            default: return 7;
        endcase
    endfunction

    always_comb begin
        head_opc = head_inst[6:0];
        exp_imm  = model_imm(head_inst);
        exp_alu  = model_alu(head_inst);
        if (head_opc == `OPC_LUI) begin
            exp_src1 = rv_decode_pkg::src1_zero;
        end else if (head_opc == `OPC_AUIPC || head_opc == `OPC_JAL) begin
            exp_src1 = rv_decode_pkg::src1_pc;
        end else begin
            exp_src1 = rv_decode_pkg::src1_reg;
        end
        exp_count = (count_sel == 3'd7) ? '0 : model_counts[count_sel];
    end

    // slot, kill flag, registers and counters.
    always @(posedge clock) begin
        int c;
        if (reset) begin
            pending.delete();
            kill_armed <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                model_counts[i] <= '0;
            end
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else begin
            if (head_valid && out_ready) begin
                c = class_of(pending[0][6:0]);
                model_counts[c] <= model_counts[c] + 1;
                void'(pending.pop_front());
            end
            if (in_valid && (!head_valid || out_ready)) begin
                if (!(flush || kill_armed)) begin
                    pending.push_back({pc, inst});
                end
                kill_armed <= 1'b0;
            end else if (flush) begin
                kill_armed <= 1'b1;
            end
            if (wb_wen && wb_rd != '0) begin
                model_regs[wb_rd] <= wb_data;
            end
        end
        head_valid <= (pending.size() != 0);
        if (pending.size() != 0) begin
            {head_pc, head_inst} <= pending[0];
        end
        loaded <= !reset && (loaded || pending.size() != 0);
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic fail_value(input string msg);
        abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
    endtask

    valid_check: assert property (@(posedge clock) disable iff (reset)
        out_valid == head_valid && in_ready == (!head_valid || out_ready))
        else fail_value("out_valid or in_ready differs from the model");

    field_check: assert property (@(posedge clock) disable iff (reset)
        head_valid |-> pc_out == head_pc && rd == head_inst[11:7] && funct3 == head_inst[14:12]
            && rs1 == head_inst[19:15] && rs2 == head_inst[24:20])
        else fail_value("pc or register fields differ from the expected instruction");

    imm_check: assert property (@(posedge clock) disable iff (reset)
        head_valid |-> imm == exp_imm)
        else fail_value("immediate differs from the expected value");

    ctrl_check: assert property (@(posedge clock) disable iff (reset)
        head_valid |-> mem_wen == (head_opc == `OPC_STORE)
            && mem_ren == (head_opc == `OPC_LOAD) && branch == (head_opc == `OPC_BRANCH)
            && jump == (head_opc == `OPC_JAL || head_opc == `OPC_JALR)
            && reg_wen == !(head_opc inside {`OPC_STORE, `OPC_BRANCH, 7'd0})
            && inv_flag == (head_opc == `OPC_BRANCH
                            && head_inst[14:12] inside {3'b000, 3'b101, 3'b111})
            && src2_imm == !(head_opc inside {`OPC_OP, `OPC_BRANCH})
            && src1_sel == exp_src1 && alu_op == exp_alu)
        else fail_value("control outputs differ from the expected decode");

    hold_check: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid && $stable(pc_out) && $stable(imm)
            && $stable(rd) && $stable(alu_op) && $stable(src1_sel))
        else fail_value("outputs changed while stalled");

    stall_check: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |-> !in_ready)
        else fail_value("in_ready high while stalled");

    reg_check: assert property (@(posedge clock) disable iff (reset)
        loaded |-> rs1_value == model_regs[head_inst[19:15]]
            && rs2_value == model_regs[head_inst[24:20]])
        else fail_value("register read differs from the model");

    count_check: assert property (@(posedge clock) disable iff (reset)
        count_value == exp_count)
        else fail_value("class counter differs from the model count");

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("timeout: the stimulus did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_inst(output rv_decode_pkg::inst_t w);
        logic [31:0] sel;
        logic [31:0] body;
        take_bits(4, sel);
        take_bits(25, body);
        w = {body[24:0], opcode_table[sel % 10]};
    endtask

    // one clock; taken tells whether the offer went through.
    task automatic drive_cycle(input logic v, input rv_decode_pkg::inst_t w,
                               input logic rdy, input logic fl, output logic taken);
        in_valid  <= v;
        inst      <= w;
        pc        <= next_pc;
        out_ready <= rdy;
        flush     <= fl;
        @(negedge clock);
        taken = v && in_ready;
        @(posedge clock);
        if (taken) begin
            next_pc = next_pc + 4;
        end
    endtask

    task automatic send(input rv_decode_pkg::inst_t w);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            drive_cycle(1'b1, w, 1'b1, 1'b0, taken);
        end
    endtask

    initial begin
        logic                 taken;
        logic                 offer;
        logic                 rdy;
        logic                 fl;
        logic [31:0]          r;
        rv_decode_pkg::inst_t word;
        reset     = 1'b1;
        in_valid  = 1'b0;
        inst      = '0;
        pc        = '0;
        flush     = 1'b0;
        out_ready = 1'b0;
        wb_wen    = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        count_sel = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        for (int s = 0; s < 8; s++) begin
            count_sel <= s[2:0];
            drive_cycle(1'b0, '0, 1'b1, 1'b0, taken);
        end
        for (int i = 0; i < 32; i++) begin
            send({7'd0, 5'(31 - i), 5'(i), 3'd0, 5'd1, `OPC_OP});
        end

        // fill every register, x0 included.
        for (int i = 0; i < 32; i++) begin
            take_bits(32, r);
            wb_wen  <= 1'b1;
            wb_rd   <= 5'(i);
            wb_data <= r;
            drive_cycle(1'b0, '0, 1'b1, 1'b0, taken);
        end
        wb_wen <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            send({7'd0, 5'(i), 5'(i), 3'd0, 5'd2, `OPC_OP});
        end

        // back-pressure with a second instruction waiting.
        random_inst(word);
        send(word);
        random_inst(word);
        repeat (5) drive_cycle(1'b1, word, 1'b0, 1'b0, taken);
        send(word);

        // kill armed while idle, then kill in the accept cycle.
        drive_cycle(1'b0, '0, 1'b1, 1'b1, taken);
        random_inst(word);
        send(word);
        random_inst(word);
        send(word);
        random_inst(word);
        drive_cycle(1'b1, word, 1'b1, 1'b1, taken);
        random_inst(word);
        send(word);

        // an all-zero word has no class and writes no register.
        send('0);

        offer = 1'b0;
        for (int n = 0; n < rand_cycles; n++) begin
            if (!offer) begin
                take_bits(1, r);
                offer = r[0];
                random_inst(word);
            end
            take_bits(2, r);
            rdy = (r[1:0] != 2'b00);
            take_bits(4, r);
            fl = (r[3:0] == 4'd0);
            take_bits(3, r);
            count_sel <= r[2:0];
            take_bits(6, r);
            wb_wen <= r[5];
            wb_rd  <= r[4:0];
            take_bits(32, r);
            wb_data <= r;
            drive_cycle(offer, word, rdy, fl, taken);
            if (taken) begin
                offer = 1'b0;
            end
        end

        wb_wen <= 1'b0;
        repeat (2) drive_cycle(1'b0, '0, 1'b1, 1'b0, taken);
        for (int s = 0; s < 8; s++) begin
            count_sel <= s[2:0];
            drive_cycle(1'b0, '0, 1'b1, 1'b0, taken);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/rv_decode_pkg.sv
hw/decode_slot.sv
hw/inst_class_counters.sv
hw/imm_gen.sv
hw/ctrl_decode.sv
hw/reg_file.sv
hw/decode_stage.sv
dv/decode_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log search decides pass or fail.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
